// File: rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int WordSize = 16;
    localparam int RegAddrW = 2;

    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opAdi   = 4'd4,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opRtype = 4'd15
    } opcode_t;

    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnWwd = 6'd28,
        fnHlt = 6'd29
    } funct_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluPassA
    } aluOp_t;

    // fwdEx only feeds the decode stage
    typedef enum logic [1:0] {
        fwdNone,
        fwdExMem,
        fwdMemWb,
        fwdEx
    } fwdSel_t;

    // all fields active high, so zero means no effects
    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   aluSrcImm;
        logic   isWwd;
        logic   isHalt;
        logic   isBranch;
        logic   isJump;
        logic   retires;
        aluOp_t aluOp;
        logic   brEq;    // BEQ when set, BNE otherwise
    } ctrl_t;

    typedef struct packed {
        logic                valid;    // cleared by bubble, opcode 0 is BNE
        logic [WordSize-1:0] pc;
        logic [WordSize-1:0] instr;
    } ifId_t;

    typedef struct packed {
        ctrl_t               ctrl;
        logic [WordSize-1:0] pc;
        logic [WordSize-1:0] opA;
        logic [WordSize-1:0] opB;
        logic [WordSize-1:0] imm;
        logic [RegAddrW-1:0] rs;
        logic [RegAddrW-1:0] rt;
        logic [RegAddrW-1:0] rd;
    } idEx_t;

    typedef struct packed {
        ctrl_t               ctrl;
        logic [WordSize-1:0] aluResult;
        logic [WordSize-1:0] storeData;
        logic [WordSize-1:0] wwdData;
        logic [RegAddrW-1:0] rd;
    } exMem_t;

    typedef struct packed {
        ctrl_t               ctrl;
        logic [WordSize-1:0] aluResult;
        logic [WordSize-1:0] memData;
        logic [WordSize-1:0] wwdData;
        logic [RegAddrW-1:0] rd;
    } memWb_t;

endpackage

`default_nettype wire

// File: rtl/hazardIf.sv
`timescale 1ns/1ns
`default_nettype none

interface hazardIf
    import cpuPkg::*;
();
    logic    pcHold;
    logic    ifIdHold;
    logic    idExBubble;
    logic    ifIdFlush;
    fwdSel_t fwdIdA;      // decode operand sources
    fwdSel_t fwdIdB;
    fwdSel_t fwdExA;      // execute operand sources
    fwdSel_t fwdExB;

    modport ctrl (
        output pcHold, ifIdHold, idExBubble, ifIdFlush,
        output fwdIdA, fwdIdB, fwdExA, fwdExB
    );

    modport path (
        input pcHold, ifIdHold, idExBubble, ifIdFlush,
        input fwdIdA, fwdIdB, fwdExA, fwdExB
    );
endinterface

`default_nettype wire

// File: rtl/pipeReg.sv
`timescale 1ns/1ns
`default_nettype none

module pipeReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // bubble wins over hold
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (bubble) begin
            q <= '0;    // zero control word, nothing happens downstream
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile
    import cpuPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [RegAddrW-1:0] rs,
    input  logic [RegAddrW-1:0] rt,
    output logic [WordSize-1:0] rdA,
    output logic [WordSize-1:0] rdB,
    input  logic [RegAddrW-1:0] wAddr,
    input  logic [WordSize-1:0] wData,
    input  logic                wEn
);

    logic [WordSize-1:0] regs [2**RegAddrW];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**RegAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (wEn) begin
            regs[wAddr] <= wData;
        end
    end

    // write-through so decode sees the writeback value this cycle
    assign rdA = (wEn && wAddr == rs) ? wData : regs[rs];
    assign rdB = (wEn && wAddr == rt) ? wData : regs[rt];

endmodule

`default_nettype wire

// File: rtl/decodeUnit.sv
`timescale 1ns/1ns
`default_nettype none

module decodeUnit
    import cpuPkg::*;
(
    input  logic [WordSize-1:0] instr,
    output ctrl_t               ctrl,
    output logic [RegAddrW-1:0] rs,
    output logic [RegAddrW-1:0] rt,
    output logic [RegAddrW-1:0] rd,
    output logic [WordSize-1:0] imm,
    output logic [11:0]         jumpTarget
);

    opcode_t opcode;
    funct_t  funct;

    assign opcode     = opcode_t'(instr[15:12]);
    assign funct      = funct_t'(instr[5:0]);
    assign rs         = instr[11:10];
    assign rt         = instr[9:8];
    assign imm        = {{(WordSize - 8){instr[7]}}, instr[7:0]};
    assign jumpTarget = instr[11:0];

    // R-type writes rd, ADI and LWD write rt
    assign rd = (opcode == opRtype) ? instr[7:6] : instr[9:8];

    always_comb begin
        ctrl = '0;
        case (opcode)
            opRtype: begin
                case (funct)
                    fnAdd, fnSub, fnAnd, fnOrr: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.retires  = 1'b1;
                        case (funct)
                            fnSub:   ctrl.aluOp = aluSub;
                            fnAnd:   ctrl.aluOp = aluAnd;
                            fnOrr:   ctrl.aluOp = aluOr;
                            default: ctrl.aluOp = aluAdd;
                        endcase
                    end
                    fnWwd: begin
                        ctrl.isWwd   = 1'b1;
                        ctrl.aluOp   = aluPassA;    // rs value rides as the result
                        ctrl.retires = 1'b1;
                    end
                    fnHlt: begin
                        ctrl.isHalt  = 1'b1;
                        ctrl.retires = 1'b1;
                    end
                    default: ctrl = '0;
                endcase
            end
            opAdi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.retires   = 1'b1;
            end
            opLwd: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;    // address is rs + imm
                ctrl.retires   = 1'b1;
            end
            opSwd: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.retires   = 1'b1;
            end
            opBne, opBeq: begin
                ctrl.isBranch = 1'b1;
                ctrl.brEq     = (opcode == opBeq);
                ctrl.retires  = 1'b1;
            end
            opJmp: begin
                ctrl.isJump  = 1'b1;
                ctrl.retires = 1'b1;
            end
            default: ctrl = '0;    // unknown opcode does nothing
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit
    import cpuPkg::*;
(
    hazardIf.ctrl              hz,
    input  ctrl_t               idCtrl,
    input  logic [RegAddrW-1:0] idRs,
    input  logic [RegAddrW-1:0] idRt,
    input  ctrl_t               exCtrl,
    input  logic [RegAddrW-1:0] exRd,
    input  logic [RegAddrW-1:0] exRs,
    input  logic [RegAddrW-1:0] exRt,
    input  ctrl_t               memCtrl,
    input  logic [RegAddrW-1:0] memRd,
    input  ctrl_t               wbCtrl,
    input  logic [RegAddrW-1:0] wbRd,
    input  logic                branchTaken
);

    logic useRs;
    logic useRt;
    logic loadUse;
    logic branchSrc;
    logic haltInFlight;
    logic stall;

    // nearest older writer wins
    function automatic fwdSel_t exSource(input logic [RegAddrW-1:0] src);
        if (memCtrl.regWrite && memRd == src)
            return fwdExMem;
        if (wbCtrl.regWrite && wbRd == src)
            return fwdMemWb;
        return fwdNone;
    endfunction

    // writeback is covered by the register file bypass
    function automatic fwdSel_t idSource(input logic [RegAddrW-1:0] src);
        if (exCtrl.regWrite && exRd == src)
            return fwdEx;
        if (memCtrl.regWrite && !memCtrl.memRead && memRd == src)
            return fwdExMem;
        return fwdNone;
    endfunction

    // which source fields the ID instruction really reads
    assign useRs = idCtrl.retires && !idCtrl.isJump && !idCtrl.isHalt;
    assign useRt = useRs && !idCtrl.isWwd && (!idCtrl.aluSrcImm || idCtrl.memWrite);

    assign loadUse = exCtrl.memRead
                  && ((useRs && exRd == idRs) || (useRt && exRd == idRt));

    assign branchSrc = idCtrl.isBranch
                    && ((exCtrl.regWrite && (exRd == idRs || exRd == idRt))
                     || (memCtrl.memRead && (memRd == idRs || memRd == idRt)));

    assign stall        = loadUse || branchSrc;
    assign haltInFlight = exCtrl.isHalt || memCtrl.isHalt || wbCtrl.isHalt;

    always_comb begin
        hz.pcHold     = stall || idCtrl.isHalt || haltInFlight;
        hz.ifIdHold   = stall;
        hz.idExBubble = stall;
        // a stalled branch has stale operands, so no redirect yet
        hz.ifIdFlush  = haltInFlight
                     || (!stall && (branchTaken || idCtrl.isJump || idCtrl.isHalt));
        hz.fwdExA     = exSource(exRs);
        hz.fwdExB     = exSource(exRt);
        hz.fwdIdA     = idSource(idRs);
        hz.fwdIdB     = idSource(idRt);
    end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
    import cpuPkg::*;
(
    input  logic [WordSize-1:0] a,
    input  logic [WordSize-1:0] b,
    input  aluOp_t              op,
    output logic [WordSize-1:0] result
);

    // plain wrap-around arithmetic, no flags
    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluPassA: result = a;    // WWD
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/pipeCpu.sv
`timescale 1ns/1ns
`default_nettype none

module pipeCpu
    import cpuPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    output logic [WordSize-1:0] iAddr,
    input  logic [WordSize-1:0] iData,
    output logic [WordSize-1:0] dAddr,
    output logic [WordSize-1:0] dWriteData,
    input  logic [WordSize-1:0] dReadData,
    output logic                dRead,
    output logic                dWrite,
    output logic [WordSize-1:0] outputPort,
    output logic                outputValid,
    output logic [WordSize-1:0] retireCount,
    output logic                halted
);

    hazardIf hz ();

    logic [WordSize-1:0] pc;
    logic [WordSize-1:0] pcNext;
    logic [WordSize-1:0] brTarget;
    logic [11:0]         jumpTarget;
    logic                branchTaken;

    ifId_t  ifIdD;
    ifId_t  ifIdQ;
    idEx_t  idExD;
    idEx_t  idExQ;
    exMem_t exMemD;
    exMem_t exMemQ;
    memWb_t memWbD;
    memWb_t memWbQ;

    ctrl_t               decCtrl;
    ctrl_t               idCtrl;
    logic [RegAddrW-1:0] idRs;
    logic [RegAddrW-1:0] idRt;
    logic [RegAddrW-1:0] idRd;
    logic [WordSize-1:0] idImm;
    logic [WordSize-1:0] rfA;
    logic [WordSize-1:0] rfB;
    logic [WordSize-1:0] idA;
    logic [WordSize-1:0] idB;
    logic [WordSize-1:0] exA;
    logic [WordSize-1:0] exB;
    logic [WordSize-1:0] aluB;
    logic [WordSize-1:0] aluResult;
    logic [WordSize-1:0] wbData;

    // decode operand mux picking the newest value
    function automatic logic [WordSize-1:0] pickOperand(
        input fwdSel_t             sel,
        input logic [WordSize-1:0] raw,
        input logic [WordSize-1:0] exVal,
        input logic [WordSize-1:0] memVal,
        input logic [WordSize-1:0] wbVal
    );
        case (sel)
            fwdEx:    return exVal;
            fwdExMem: return memVal;
            fwdMemWb: return wbVal;
            default:  return raw;
        endcase
    endfunction

    // fetch
    always_comb begin
        if (hz.pcHold || halted)
            pcNext = pc;
        else if (branchTaken)
            pcNext = brTarget;
        else if (idCtrl.isJump)
            pcNext = {ifIdQ.pc[WordSize-1:12], jumpTarget};
        else
            pcNext = pc + WordSize'(1);
    end

    always_ff @(posedge clk) begin
        if (rst)
            pc <= '0;
        else
            pc <= pcNext;
    end

    assign iAddr = pc;
    assign ifIdD = '{valid: 1'b1, pc: pc, instr: iData};

    pipeReg #(.payload_t(ifId_t)) ifIdReg (
        .clk    (clk),
        .rst    (rst),
        .hold   (hz.ifIdHold),
        .bubble (hz.ifIdFlush || halted),    // nothing new enters after halt
        .d      (ifIdD),
        .q      (ifIdQ)
    );

    // decode
    decodeUnit decoder (
        .instr      (ifIdQ.instr),
        .ctrl       (decCtrl),
        .rs         (idRs),
        .rt         (idRt),
        .rd         (idRd),
        .imm        (idImm),
        .jumpTarget (jumpTarget)
    );

    assign idCtrl = ifIdQ.valid ? decCtrl : '0;

    regFile regs (
        .clk   (clk),
        .rst   (rst),
        .rs    (idRs),
        .rt    (idRt),
        .rdA   (rfA),
        .rdB   (rfB),
        .wAddr (memWbQ.rd),
        .wData (wbData),
        .wEn   (memWbQ.ctrl.regWrite)
    );

    assign idA = pickOperand(hz.fwdIdA, rfA, aluResult, exMemQ.aluResult, wbData);
    assign idB = pickOperand(hz.fwdIdB, rfB, aluResult, exMemQ.aluResult, wbData);

    // branches resolve here and cost one bubble when taken
    assign brTarget    = ifIdQ.pc + WordSize'(1) + idImm;
    assign branchTaken = idCtrl.isBranch && (idCtrl.brEq ? (idA == idB) : (idA != idB));

    hazardUnit hazard (
        .hz          (hz.ctrl),
        .idCtrl      (idCtrl),
        .idRs        (idRs),
        .idRt        (idRt),
        .exCtrl      (idExQ.ctrl),
        .exRd        (idExQ.rd),
        .exRs        (idExQ.rs),
        .exRt        (idExQ.rt),
        .memCtrl     (exMemQ.ctrl),
        .memRd       (exMemQ.rd),
        .wbCtrl      (memWbQ.ctrl),
        .wbRd        (memWbQ.rd),
        .branchTaken (branchTaken)
    );

    assign idExD = '{ctrl: idCtrl, pc: ifIdQ.pc, opA: idA, opB: idB, imm: idImm,
                     rs: idRs, rt: idRt, rd: idRd};

    pipeReg #(.payload_t(idEx_t)) idExReg (
        .clk    (clk),
        .rst    (rst),
        .hold   (1'b0),
        .bubble (hz.idExBubble),
        .d      (idExD),
        .q      (idExQ)
    );

    // execute
    assign exA  = (hz.fwdExA == fwdExMem) ? exMemQ.aluResult :
                  (hz.fwdExA == fwdMemWb) ? wbData : idExQ.opA;
    assign exB  = (hz.fwdExB == fwdExMem) ? exMemQ.aluResult :
                  (hz.fwdExB == fwdMemWb) ? wbData : idExQ.opB;
    assign aluB = idExQ.ctrl.aluSrcImm ? idExQ.imm : exB;

    alu aluEx (
        .a      (exA),
        .b      (aluB),
        .op     (idExQ.ctrl.aluOp),
        .result (aluResult)
    );

    assign exMemD = '{ctrl: idExQ.ctrl, aluResult: aluResult, storeData: exB,
                      wwdData: exA, rd: idExQ.rd};

    pipeReg #(.payload_t(exMem_t)) exMemReg (
        .clk    (clk),
        .rst    (rst),
        .hold   (1'b0),
        .bubble (1'b0),
        .d      (exMemD),
        .q      (exMemQ)
    );

    // memory strobes last exactly one cycle
    assign dAddr      = exMemQ.aluResult;
    assign dWriteData = exMemQ.storeData;
    assign dRead      = exMemQ.ctrl.memRead;
    assign dWrite     = exMemQ.ctrl.memWrite;

    assign memWbD = '{ctrl: exMemQ.ctrl, aluResult: exMemQ.aluResult, memData: dReadData,
                      wwdData: exMemQ.wwdData, rd: exMemQ.rd};

    pipeReg #(.payload_t(memWb_t)) memWbReg (
        .clk    (clk),
        .rst    (rst),
        .hold   (1'b0),
        .bubble (1'b0),
        .d      (memWbD),
        .q      (memWbQ)
    );

    // writeback
    assign wbData      = memWbQ.ctrl.memToReg ? memWbQ.memData : memWbQ.aluResult;
    assign outputPort  = memWbQ.wwdData;
    assign outputValid = memWbQ.ctrl.isWwd;

    always_ff @(posedge clk) begin
        if (rst) begin
            retireCount <= '0;
            halted      <= 1'b0;
        end else begin
            if (memWbQ.ctrl.retires)
                retireCount <= retireCount + WordSize'(1);
            if (memWbQ.ctrl.isHalt)
                halted <= 1'b1;    // sticky until reset
        end
    end

endmodule

`default_nettype wire

// File: test/tbPipeCpu.sv
`timescale 1ns/1ns
`default_nettype none

module tbPipeCpu
    import cpuPkg::*;
();

    logic                clk = 1'b0;
    logic                rst;
    logic [WordSize-1:0] iAddr;
    logic [WordSize-1:0] iData;
    logic [WordSize-1:0] dAddr;
    logic [WordSize-1:0] dWriteData;
    logic [WordSize-1:0] dReadData;
    logic                dRead;
    logic                dWrite;
    logic [WordSize-1:0] outputPort;
    logic                outputValid;
    logic [WordSize-1:0] retireCount;
    logic                halted;

    logic [WordSize-1:0] imem [256];
    logic [WordSize-1:0] dmem [256];

    logic [WordSize-1:0] expOut [$];    // WWD values in program order
    int                  expMemAddr [$];
    logic [WordSize-1:0] expMemData [$];
    logic [WordSize-1:0] expRetire;
    int                  instrCount = 0;
    int                  outIdx = 0;
    int                  errorCount = 0;
    logic                traceReady = 1'b0;

    always #5 clk = ~clk;

    pipeCpu i_dut (
        .clk         (clk),
        .rst         (rst),
        .iAddr       (iAddr),
        .iData       (iData),
        .dAddr       (dAddr),
        .dWriteData  (dWriteData),
        .dReadData   (dReadData),
        .dRead       (dRead),
        .dWrite      (dWrite),
        .outputPort  (outputPort),
        .outputValid (outputValid),
        .retireCount (retireCount),
        .halted      (halted)
    );

    // both memories answer in the same cycle
    assign iData     = imem[iAddr[7:0]];
    assign dReadData = (dRead === 1'b1) ? dmem[dAddr[7:0]] : 'x;    // only during a load

    always @(posedge clk) begin
        if (dWrite === 1'b1)
            dmem[dAddr[7:0]] <= dWriteData;    // store lands at the end of the strobe
    end

    task automatic reportFailure(input string why);
        errorCount++;
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkWord(input string name, input logic [WordSize-1:0] expected,
                             input logic [WordSize-1:0] actual);
        if (actual !== expected)
            reportFailure($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic checkCount(input string name, input logic [WordSize-1:0] expected,
                              input logic [WordSize-1:0] actual);
        if (actual !== expected)
            reportFailure($sformatf("[FAIL] %s expected %0d actual %0d", name, expected, actual));
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            reportFailure($sformatf("[FAIL] %s expected %b actual %b", name, expected, actual));
    endtask

    // tagged lines as described at the head of the trace file
    task automatic loadTrace();
        int                  fd;
        int                  code;
        logic [63:0]         tag;
        logic [8*160-1:0]    rest;
        logic [WordSize-1:0] addr;
        logic [WordSize-1:0] value;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = {~i[7:0], i[7:0]};
        end
        fd = $fopen("test/pipeCpu_trace.txt", "r");
        if (fd == 0)
            reportFailure("could not open the trace file test/pipeCpu_trace.txt");
        code = $fscanf(fd, "%s", tag);
        while (code == 1) begin
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "I" || tag == "D" || tag == "M") begin
                code = $fscanf(fd, "%h %h", addr, value);
                if (code != 2)
                    reportFailure("a trace line lacks its address or its word");
                if (tag == "I") begin
                    imem[addr[7:0]] = value;
                    instrCount++;
                end else if (tag == "D") begin
                    dmem[addr[7:0]] = value;
                end else begin
                    expMemAddr.push_back(int'(addr[7:0]));
                    expMemData.push_back(value);
                end
            end else if (tag == "O") begin
                code = $fscanf(fd, "%h", value);
                if (code != 1)
                    reportFailure("an expected output line in the trace lacks its value");
                expOut.push_back(value);
            end else if (tag == "R") begin
                code = $fscanf(fd, "%h", expRetire);
                if (code != 1)
                    reportFailure("the retire count line in the trace lacks its value");
            end else begin
                reportFailure("the trace file holds an unknown tag");
            end
            code = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
    endtask

    // every WWD pulse takes the next expected value
    always @(negedge clk) begin
        if (rst === 1'b0 && outputValid === 1'b1) begin
            if (halted)
                reportFailure("outputValid pulsed after the core had halted");
            else if (outIdx >= expOut.size())
                reportFailure("the core wrote more WWD values than the trace expects");
            else
                checkWord($sformatf("wwd output %0d", outIdx), expOut[outIdx], outputPort);
            outIdx++;
        end
    end

    initial begin
        wait (traceReady);
        repeat (instrCount * 4 + 50) @(posedge clk);
        reportFailure($sformatf("timeout, the core never halted within %0d cycles",
                                instrCount * 4 + 50));
    end

    initial begin
        rst = 1'b1;
        loadTrace();
        traceReady = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        while (halted !== 1'b1) @(negedge clk);
        // halt must stick and the port must stay quiet
        repeat (10) begin
            @(negedge clk);
            checkFlag("halted stays high", 1'b1, halted);
        end
        if (outIdx != expOut.size())
            reportFailure($sformatf("the core wrote %0d WWD values but the trace expects %0d",
                                    outIdx, expOut.size()));
        checkCount("retire count", expRetire, retireCount);
        foreach (expMemAddr[k]) begin
            checkWord($sformatf("dmem[%0h]", expMemAddr[k]), expMemData[k],
                      dmem[expMemAddr[k]]);
        end
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/pipeCpu_trace.txt
# columns: I addr instr | D addr initial data | O expected WWD value, in order
# columns: R expected retire count | M addr expected final data word (all hex)
D 0010 1234
D 0011 00f0
I 00 4105
I 01 4603
I 02 f6c0
I 03 fc1c
I 04 fd01
I 05 f01c
I 06 fe42
I 07 f783
I 08 f81c
I 09 40ff
I 0a f01c
I 0b 7109
I 0c f580
I 0d f81c
I 0e 8219
I 0f 7319
I 10 fdc1
I 11 fc1c
I 12 831a
I 13 1d01
I 14 f41c
I 15 4501
I 16 0702
I 17 f41c
I 18 f01d
I 19 1703
I 1a 0f05
I 1b f41c
I 1c 901f
I 1d fc1c
I 1e fc1c
I 1f 721a
I 20 1b01
I 21 f81c
I 22 f900
I 23 f01c
I 24 f01d
I 25 f01c
O 000d
O 0008
O 000d
O 0007
O 2468
O 1234
O 1235
O 2469
R 001f
M 0010 1234
M 0011 00f0
M 0020 2468
M 0021 1234

// File: files.f
rtl/cpuPkg.sv
rtl/hazardIf.sv
rtl/pipeReg.sv
rtl/regFile.sv
rtl/decodeUnit.sv
rtl/hazardUnit.sv
rtl/alu.sv
rtl/pipeCpu.sv
test/tbPipeCpu.sv

// File: Bender.yml
package:
  name: pipe_cpu

sources:
  - target: any(rtl, test)
    files:
      - rtl/cpuPkg.sv
      - rtl/hazardIf.sv
      - rtl/pipeReg.sv
      - rtl/regFile.sv
      - rtl/decodeUnit.sv
      - rtl/hazardUnit.sv
      - rtl/alu.sv
      - rtl/pipeCpu.sv
  - target: test
    files:
      - test/tbPipeCpu.sv
